/* common/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Rename lanes handled per cycle
`define RN_LANES      2

// Physical register file size
`define RN_PHYS_REGS  48

// Architectural registers, x0 included
`define RN_ARCH_REGS  32

// Physical tag width
`define RN_TAG_W      6

`endif

/* common/rename_pkg.sv */
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    // Tag and register index types
    typedef logic [`RN_TAG_W-1:0]              phys_tag_t;
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0]  arch_reg_t;

    // One lane of a rename group, rd of x0 means no destination
    typedef struct packed {
        logic      valid;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_req_t;

    // Renamed sources and new destination tag, pd is zero without rd
    typedef struct packed {
        logic      accepted;
        phys_tag_t ps1;
        phys_tag_t ps2;
        phys_tag_t pd;
    } rename_resp_t;

    // Retiring instruction and the tag it made architectural
    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        phys_tag_t pd;
    } retire_t;

    // Lane classes seen by the acceptance scan
    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_NO_DEST,
        LANE_ALLOC,
        LANE_BLOCKED
    } lane_kind_e;

endpackage

`default_nettype wire

/* free_list/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list #(
    parameter int N          = `RN_LANES,
    parameter int PR_COUNT   = `RN_PHYS_REGS,
    parameter int ARCH_COUNT = `RN_ARCH_REGS
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset_n,
    input  wire logic                       [N-1:0]   i_alloc_en,
    input  wire logic                       [N-1:0]   i_return_en,
    input  wire rename_pkg::phys_tag_t      [N-1:0]   i_return_tag,
    output rename_pkg::phys_tag_t           [N-1:0]   o_alloc_tag,
    output logic                            [N-1:0]   o_alloc_valid,
    output logic [$clog2(PR_COUNT+1)-1:0]             o_free_count,
    output logic [$clog2(N+1)-1:0]                    o_free_slots
);

    // Queue holds every tag above the architectural range
    localparam int DEPTH = PR_COUNT - ARCH_COUNT;
    localparam int PTRW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW  = $clog2(PR_COUNT + 1);
    localparam int SLOTW = $clog2(N + 1);

    rename_pkg::phys_tag_t queue [DEPTH];

    logic [PTRW-1:0] head;
    logic [PTRW-1:0] tail;
    logic [CNTW-1:0] count;

    logic [PTRW-1:0] head_n;
    logic [PTRW-1:0] tail_n;
    logic [CNTW-1:0] count_n;

    // Write slot of each return lane
    logic [PTRW-1:0] push_slot [N];

    // Number of set strobes
    function automatic int count_ones(input logic [N-1:0] bits);
        int total;
        total = 0;
        for (int b = 0; b < N; b++) begin
            if (bits[b]) total = total + 1;
        end
        return total;
    endfunction

    // Pointer advance with wrap, offset never exceeds N
    function automatic logic [PTRW-1:0] wrap_add(input logic [PTRW-1:0] base, input int offs);
        int sum;
        sum = int'(base) + offs;
        if (sum >= DEPTH) sum = sum - DEPTH;
        return sum[PTRW-1:0];
    endfunction

    // ------------------------------------------------------------------
    // Grant and pointer next state
    // ------------------------------------------------------------------
    always_comb begin : grant_logic
        int req_pop;
        int req_push;
        int grant;
        req_pop  = count_ones(i_alloc_en);
        req_push = count_ones(i_return_en);
        // Clamp on own count, oldest lanes first
        grant = (int'(count) < req_pop) ? int'(count) : req_pop;
        for (int i = 0; i < N; i++) begin
            o_alloc_valid[i] = (i < grant);
            o_alloc_tag[i]   = (i < grant) ? queue[wrap_add(head, i)] : '0;
        end
        head_n  = wrap_add(head, grant);
        tail_n  = wrap_add(tail, req_push);
        count_n = count - CNTW'(grant) + CNTW'(req_push);
    end

    // Returned tags land at the tail in lane order
    always_comb begin : push_logic
        int offs;
        offs = 0;
        for (int i = 0; i < N; i++) begin
            push_slot[i] = wrap_add(tail, offs);
            if (i_return_en[i]) offs = offs + 1;
        end
    end

    // Status from the registered count only
    assign o_free_count = count;
    assign o_free_slots = (count >= CNTW'(N)) ? SLOTW'(N) : count[SLOTW-1:0];

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head  <= '0;
            tail  <= '0;
            count <= CNTW'(DEPTH);
            // Seed with ARCH_COUNT .. PR_COUNT-1 in order
            for (int s = 0; s < DEPTH; s++) begin
                queue[s] <= rename_pkg::phys_tag_t'(ARCH_COUNT + s);
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i_return_en[i]) queue[push_slot[i]] <= i_return_tag[i];
            end
            head  <= head_n;
            tail  <= tail_n;
            count <= count_n;
        end
    end

endmodule

`default_nettype wire

/* map_table/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table #(
    parameter int N = `RN_LANES
) (
    input  wire logic                              clock,
    input  wire logic                              reset_n,
    input  wire rename_pkg::rename_req_t  [N-1:0]  i_req,
    input  wire rename_pkg::phys_tag_t    [N-1:0]  i_free_tag,
    input  wire logic                     [N-1:0]  i_free_valid,
    input  wire logic        [$clog2(N+1)-1:0]     i_free_slots,
    output logic                          [N-1:0]  o_alloc_en,
    output rename_pkg::rename_resp_t      [N-1:0]  o_resp
);

    localparam int SLOTW = $clog2(N + 1);
    localparam int IDXW  = (N > 1) ? $clog2(N) : 1;

    // Speculative arch to phys map
    rename_pkg::phys_tag_t spec_map [`RN_ARCH_REGS];

    rename_pkg::lane_kind_e lane_kind [N];
    logic [N-1:0]           lane_ok;
    // Position of the lane among allocating lanes
    logic [IDXW-1:0]        alloc_idx [N];

    // ------------------------------------------------------------------
    // Acceptance scan
    // ------------------------------------------------------------------
    // Depends on requests and slot count only, never on granted tags
    always_comb begin : accept_scan
        logic             stop;
        logic [SLOTW-1:0] need;
        stop = 1'b0;
        need = '0;
        for (int i = 0; i < N; i++) begin
            alloc_idx[i] = need[IDXW-1:0];
            if (!i_req[i].valid) begin
                // A hole ends the in-order prefix
                lane_kind[i] = rename_pkg::LANE_IDLE;
                stop         = 1'b1;
            end else if (stop) begin
                lane_kind[i] = rename_pkg::LANE_BLOCKED;
            end else if (i_req[i].rd == '0) begin
                lane_kind[i] = rename_pkg::LANE_NO_DEST;
            end else if (need < i_free_slots) begin
                lane_kind[i] = rename_pkg::LANE_ALLOC;
                need         = need + SLOTW'(1);
            end else begin
                // Out of tags, this lane and all younger ones wait
                lane_kind[i] = rename_pkg::LANE_BLOCKED;
                stop         = 1'b1;
            end
            lane_ok[i] = (lane_kind[i] == rename_pkg::LANE_NO_DEST) ||
                         (lane_kind[i] == rename_pkg::LANE_ALLOC);
        end
        // Compacted strobes, first k bits for k tags
        for (int k = 0; k < N; k++) begin
            o_alloc_en[k] = (k < int'(need));
        end
    end

    // ------------------------------------------------------------------
    // Source lookup with bypass from older lanes
    // ------------------------------------------------------------------
    always_comb begin : resp_logic
        for (int i = 0; i < N; i++) begin
            o_resp[i].accepted = lane_ok[i];
            o_resp[i].ps1      = spec_map[i_req[i].rs1];
            o_resp[i].ps2      = spec_map[i_req[i].rs2];
            // Youngest older writer of the same rd wins
            for (int j = 0; j < i; j++) begin
                if (lane_kind[j] == rename_pkg::LANE_ALLOC) begin
                    if (i_req[j].rd == i_req[i].rs1) o_resp[i].ps1 = i_free_tag[alloc_idx[j]];
                    if (i_req[j].rd == i_req[i].rs2) o_resp[i].ps2 = i_free_tag[alloc_idx[j]];
                end
            end
            // x0 is hardwired to tag 0
            if (i_req[i].rs1 == '0) o_resp[i].ps1 = '0;
            if (i_req[i].rs2 == '0) o_resp[i].ps2 = '0;
            o_resp[i].pd = (lane_kind[i] == rename_pkg::LANE_ALLOC) ?
                           i_free_tag[alloc_idx[i]] : '0;
        end
    end

    // ------------------------------------------------------------------
    // Map update, later lane overwrites earlier one
    // ------------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                spec_map[r] <= rename_pkg::phys_tag_t'(r);
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (lane_kind[i] == rename_pkg::LANE_ALLOC && i_free_valid[alloc_idx[i]]) begin
                    spec_map[i_req[i].rd] <= i_free_tag[alloc_idx[i]];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/retire_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module retire_map #(
    parameter int N = `RN_LANES
) (
    input  wire logic                             clock,
    input  wire logic                             reset_n,
    input  wire rename_pkg::retire_t     [N-1:0]  i_retire,
    output logic                         [N-1:0]  o_return_en,
    output rename_pkg::phys_tag_t        [N-1:0]  o_return_tag
);

    // Committed arch to phys map
    rename_pkg::phys_tag_t arch_map [`RN_ARCH_REGS];

    // ------------------------------------------------------------------
    // Displaced tag per retire lane
    // ------------------------------------------------------------------
    always_comb begin : displaced_logic
        logic frees;
        for (int i = 0; i < N; i++) begin
            frees           = i_retire[i].valid && (i_retire[i].rd != '0);
            o_return_en[i]  = frees;
            o_return_tag[i] = arch_map[i_retire[i].rd];
            // Older lane retiring the same rd displaced the map first
            for (int j = 0; j < i; j++) begin
                if (i_retire[j].valid && i_retire[j].rd == i_retire[i].rd) begin
                    o_return_tag[i] = i_retire[j].pd;
                end
            end
            if (!frees) o_return_tag[i] = '0;
        end
    end

    // Identity at reset, youngest retire of an rd wins
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                arch_map[r] <= rename_pkg::phys_tag_t'(r);
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i_retire[i].valid && i_retire[i].rd != '0) begin
                    arch_map[i_retire[i].rd] <= i_retire[i].pd;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_stage #(
    parameter int N          = `RN_LANES,
    parameter int PR_COUNT   = `RN_PHYS_REGS,
    parameter int ARCH_COUNT = `RN_ARCH_REGS
) (
    input  wire logic                               clock,
    input  wire logic                               reset_n,
    input  wire rename_pkg::rename_req_t  [N-1:0]   i_req,
    input  wire rename_pkg::retire_t      [N-1:0]   i_retire,
    output rename_pkg::rename_resp_t      [N-1:0]   o_resp,
    output logic [$clog2(PR_COUNT+1)-1:0]           o_free_count
);

    // Allocation path, map table to free list
    logic                  [N-1:0]  alloc_en;
    rename_pkg::phys_tag_t [N-1:0]  alloc_tag;
    logic                  [N-1:0]  alloc_valid;
    logic      [$clog2(N+1)-1:0]    free_slots;

    // Recycle path, retire map to free list
    logic                  [N-1:0]  return_en;
    rename_pkg::phys_tag_t [N-1:0]  return_tag;

    free_list #(
        .N          (N),
        .PR_COUNT   (PR_COUNT),
        .ARCH_COUNT (ARCH_COUNT)
    ) u_free_list (
        .clock         (clock),
        .reset_n       (reset_n),
        .i_alloc_en    (alloc_en),
        .i_return_en   (return_en),
        .i_return_tag  (return_tag),
        .o_alloc_tag   (alloc_tag),
        .o_alloc_valid (alloc_valid),
        .o_free_count  (o_free_count),
        .o_free_slots  (free_slots)
    );

    map_table #(
        .N (N)
    ) u_map_table (
        .clock        (clock),
        .reset_n      (reset_n),
        .i_req        (i_req),
        .i_free_tag   (alloc_tag),
        .i_free_valid (alloc_valid),
        .i_free_slots (free_slots),
        .o_alloc_en   (alloc_en),
        .o_resp       (o_resp)
    );

    retire_map #(
        .N (N)
    ) u_retire_map (
        .clock        (clock),
        .reset_n      (reset_n),
        .i_retire     (i_retire),
        .o_return_en  (return_en),
        .o_return_tag (return_tag)
    );

endmodule

`default_nettype wire

/* bench/rename_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_stage_props #(
    parameter int N          = `RN_LANES,
    parameter int PR_COUNT   = `RN_PHYS_REGS,
    parameter int ARCH_COUNT = `RN_ARCH_REGS
) (
    input wire logic                                clock,
    input wire logic                                reset_n,
    input wire logic                      [N-1:0]   alloc_valid,
    input wire rename_pkg::phys_tag_t     [N-1:0]   alloc_tag,
    input wire logic                      [N-1:0]   return_en,
    input wire rename_pkg::phys_tag_t     [N-1:0]   return_tag,
    input wire logic [$clog2(PR_COUNT+1)-1:0]       free_count,
    input wire rename_pkg::rename_resp_t  [N-1:0]   resp
);

    // One bit per physical tag, set while the tag is mapped somewhere
    logic [PR_COUNT-1:0] in_use;

    // Returns clear first, then this cycle's grants mark their tags
    always_ff @(posedge clock or negedge reset_n) begin : track_in_use
        logic [PR_COUNT-1:0] next_use;
        if (!reset_n) begin
            // Architectural tags start mapped, the rest sit in the free list
            in_use <= {{(PR_COUNT-ARCH_COUNT){1'b0}}, {ARCH_COUNT{1'b1}}};
        end else begin
            next_use = in_use;
            for (int i = 0; i < N; i++) begin
                if (return_en[i]) next_use[return_tag[i]] = 1'b0;
            end
            for (int i = 0; i < N; i++) begin
                if (alloc_valid[i]) next_use[alloc_tag[i]] = 1'b1;
            end
            in_use <= next_use;
        end
    end

    // ------------------------------------------------------------------
    // Free list and top level properties
    // ------------------------------------------------------------------
    a_count_bound: assert property (@(posedge clock) disable iff (!reset_n)
        int'(free_count) <= PR_COUNT - ARCH_COUNT)
        else $error("free count above the free list depth");

    // Grants form a prefix of the lanes
    a_grant_prefix: assert property (@(posedge clock) disable iff (!reset_n)
        (alloc_valid & (alloc_valid + N'(1))) == '0)
        else $error("alloc_valid is not a prefix");

    for (genvar i = 0; i < N; i++) begin : g_lane
        a_reject_pd: assert property (@(posedge clock) disable iff (!reset_n)
            !resp[i].accepted |-> resp[i].pd == '0)
            else $error("rejected lane %0d carries a nonzero pd", i);

        a_unique_grant: assert property (@(posedge clock) disable iff (!reset_n)
            alloc_valid[i] |-> !in_use[alloc_tag[i]])
            else $error("lane %0d granted a tag that is still in use", i);
    end

endmodule

`default_nettype wire

/* bench/rename_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_stage_tb;

    localparam int    N         = `RN_LANES;
    localparam int    MAX_LINES = 200;
    localparam int    MAX_GAP   = 2;
    localparam string DATA_FILE = "bench/rename_testdata.txt";

    logic                                clock;
    logic                                reset_n;
    rename_pkg::rename_req_t   [N-1:0]   req;
    rename_pkg::retire_t       [N-1:0]   retire;
    rename_pkg::rename_resp_t  [N-1:0]   resp;
    logic [$clog2(`RN_PHYS_REGS+1)-1:0]  free_count;

    // Fields of the current data line, indexed by lane
    int req_v   [N];
    int req_rs1 [N];
    int req_rs2 [N];
    int req_rd  [N];
    int ret_v   [N];
    int ret_rd  [N];
    int ret_pd  [N];
    int exp_acc [N];
    int exp_ps1 [N];
    int exp_ps2 [N];
    int exp_pd  [N];
    int exp_count;
    // Free count expected after the last applied edge
    int count_model;

    rename_stage #(
        .N          (N),
        .PR_COUNT   (`RN_PHYS_REGS),
        .ARCH_COUNT (`RN_ARCH_REGS)
    ) u_rename_stage (
        .clock        (clock),
        .reset_n      (reset_n),
        .i_req        (req),
        .i_retire     (retire),
        .o_resp       (resp),
        .o_free_count (free_count)
    );

    // Free list nets are visible at the top level
    bind rename_stage rename_stage_props #(
        .N          (N),
        .PR_COUNT   (PR_COUNT),
        .ARCH_COUNT (ARCH_COUNT)
    ) u_rename_props (
        .clock       (clock),
        .reset_n     (reset_n),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .return_en   (return_en),
        .return_tag  (return_tag),
        .free_count  (o_free_count),
        .resp        (o_resp)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input string what, input int expected,
                               input int actual);
        if (expected != actual) begin
            $display("ERR %s %s expected %0d actual %0d", name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic drive_idle();
        for (int i = 0; i < N; i++) begin
            req[i]    = '0;
            retire[i] = '0;
        end
    endtask

    task automatic drive_line();
        for (int i = 0; i < N; i++) begin
            req[i].valid    = (req_v[i] != 0);
            req[i].rs1      = rename_pkg::arch_reg_t'(req_rs1[i]);
            req[i].rs2      = rename_pkg::arch_reg_t'(req_rs2[i]);
            req[i].rd       = rename_pkg::arch_reg_t'(req_rd[i]);
            retire[i].valid = (ret_v[i] != 0);
            retire[i].rd    = rename_pkg::arch_reg_t'(ret_rd[i]);
            retire[i].pd    = rename_pkg::phys_tag_t'(ret_pd[i]);
        end
    endtask

    task automatic check_line(input string name);
        for (int i = 0; i < N; i++) begin
            check_value(name, $sformatf("lane%0d accepted", i), exp_acc[i],
                        int'(resp[i].accepted));
            check_value(name, $sformatf("lane%0d ps1", i), exp_ps1[i], int'(resp[i].ps1));
            check_value(name, $sformatf("lane%0d ps2", i), exp_ps2[i], int'(resp[i].ps2));
            check_value(name, $sformatf("lane%0d pd", i), exp_pd[i], int'(resp[i].pd));
        end
        check_value(name, "free count", exp_count, int'(free_count));
    endtask

    // No request, no retire, count holds
    task automatic check_idle(input string name);
        for (int i = 0; i < N; i++) begin
            check_value(name, $sformatf("lane%0d accepted", i), 0, int'(resp[i].accepted));
            check_value(name, $sformatf("lane%0d pd", i), 0, int'(resp[i].pd));
        end
        check_value(name, "free count", count_model, int'(free_count));
    endtask

    // Count after the edge, from the line's own expected values
    function automatic int count_after_line();
        int total;
        total = exp_count;
        for (int i = 0; i < N; i++) begin
            // Accepted lane with a destination takes one tag
            if (exp_acc[i] != 0 && req_rd[i] != 0) total = total - 1;
            // Retire of a nonzero rd hands one back
            if (ret_v[i] != 0 && ret_rd[i] != 0) total = total + 1;
        end
        return total;
    endfunction

    task automatic run_gap(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clock);
            #1 drive_idle();
            #2 check_idle("idle_gap");
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main
        int    fd;
        int    code;
        int    items;
        int    lines_read;
        int    gap_len;
        bit    done;
        string line;
        string name;

        reset_n = 1'b0;
        drive_idle();
        void'($urandom(16834));
        // Sixteen tags above the architectural range after reset
        count_model = `RN_PHYS_REGS - `RN_ARCH_REGS;
        repeat (3) @(posedge clock);
        #1 reset_n = 1'b1;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) abort_run("could not open the test data file");
        lines_read = 0;
        done       = 1'b0;
        while (!done) begin
            code       = $fgets(line, fd);
            lines_read = lines_read + 1;
            if (code == 0) begin
                done = 1'b1;
            end else if (lines_read > MAX_LINES) begin
                abort_run("test data file exceeds the line limit");
            end else if (line.len() > 1 && line.getc(0) != "#") begin
                items = $sscanf(line,
                    "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    name, req_v[0], req_rs1[0], req_rs2[0], req_rd[0],
                    req_v[1], req_rs1[1], req_rs2[1], req_rd[1],
                    ret_v[0], ret_rd[0], ret_pd[0], ret_v[1], ret_rd[1], ret_pd[1],
                    exp_acc[0], exp_ps1[0], exp_ps2[0], exp_pd[0],
                    exp_acc[1], exp_ps1[1], exp_ps2[1], exp_pd[1], exp_count);
                if (items != 24) begin
                    abort_run($sformatf("malformed test data at line %0d", lines_read));
                end
                // Random idle cycles ahead of each data line
                gap_len = $urandom_range(MAX_GAP, 0);
                run_gap(gap_len);
                @(posedge clock);
                #1 drive_line();
                // Rename is combinational, sample mid cycle
                #2 check_line(name);
                count_model = count_after_line();
            end
        end
        $fclose(fd);
        // One idle cycle shows the final count
        run_gap(1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rename_testdata.txt */
# name | req0 v rs1 rs2 rd | req1 v rs1 rs2 rd | ret0 v rd pd | ret1 v rd pd
# exp0 acc ps1 ps2 pd | exp1 acc ps1 ps2 pd | free_count during the cycle
reset_idle       0  3  7  0   0 10 31  0   0  0  0   0  0  0   0  3  7  0   0 10 31  0  16
alloc_pair_a     1  1  2  5   1  4  6  3   0  0  0   0  0  0   1  1  2 32   1  4  6 33  16
alloc_pair_b     1  8  9  7   1 10 11  8   0  0  0   0  0  0   1  8  9 34   1 10 11 35  14
bypass_rd        1  3  5  9   1  9  0  0   0  0  0   0  0  0   1 33 32 36   1 36  0  0  12
x0_dest          1  0  9  0   1  7  8 10   0  0  0   0  0  0   1  0 36  0   1 34 35 37  11
renamed_read     1 10  3  0   1  9  5  0   0  0  0   0  0  0   1 37 33  0   1 36 32  0  10
same_rd_pair     1  4  0  4   1  4  4  4   0  0  0   0  0  0   1  4  0 38   1 38 38 39  10
drain_a          1  4  0 11   1 11 12 12   0  0  0   0  0  0   1 39  0 40   1 40 12 41   8
drain_b          1 12 13 13   1 13 14 14   0  0  0   0  0  0   1 41 13 42   1 42 14 43   6
drain_c          1  1  1 15   1 15 16 16   0  0  0   0  0  0   1  1  1 44   1 44 16 45   4
drain_d          1 17  0 17   1  0  0  0   0  0  0   0  0  0   1 17  0 46   1  0  0  0   2
one_tag_left     1 17 18 18   1 18 19 19   0  0  0   0  0  0   1 46 18 47   0 47 19  0   1
no_tag_left      1 18  2 19   1 19 20 20   0  0  0   0  0  0   0 47  2  0   0 19 20  0   0
nodest_blocked   1  1  2 19   1  3  4  0   0  0  0   0  0  0   0  1  2  0   0 33 39  0   0
retire_rd5       1  5  0 19   0  0  0  0   1  5 32   0  0  0   0 32  0  0   0  0  0  0   0
retire_double    0  0  0  0   0  0  0  0   1  3 33   1  3 38   0  0  0  0   0  0  0  0   1
recycle_a        1  0  0 20   1 20 21 21   1  7 34   0  0  0   1  0  0  5   1  5 21  3   3
recycle_b        1 20 21 22   1 22  0 23   0  0  0   0  0  0   1  5  3 33   1 33  0  7   2
retire_no_free   0  0  0  0   0  0  0  0   1 20  5   1  0  0   0  0  0  0   0  0  0  0   0
final_read       0 22 23  0   0 20  0  0   0  0  0   0  0  0   0 33  7  0   0  5  0  0   1

/* rename_stage.f */
+incdir+common
common/rename_pkg.sv
free_list/free_list.sv
map_table/map_table.sv
logic/retire_map.sv
logic/rename_stage.sv
bench/rename_stage_props.sv
bench/rename_stage_tb.sv

/* Makefile */
# Verilator build and run of the rename stage testbench

SRCS := $(wildcard common/*.sv common/*.svh free_list/*.sv map_table/*.sv logic/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vrename_stage_tb: rename_stage.f $(SRCS)
	verilator --binary --timing --assert --top-module rename_stage_tb \
		-f rename_stage.f -o Vrename_stage_tb

run: obj_dir/Vrename_stage_tb bench/rename_testdata.txt
	./obj_dir/Vrename_stage_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
